/* flist.f */
+incdir+include
src/tx_pack.sv
src/tx_debug_intf.sv
src/input_divider.sv
src/hr_16t4_mux.sv
src/qr_4t1_mux.sv
src/phase_interpolator.sv
src/tx_top.sv
test/tx_checker.sv
test/tb_tx_top.sv

/* include/tx_defs.svh */
`ifndef TX_DEFS_SVH
`define TX_DEFS_SVH

`define TX_WORD_W 16 // Parallel word from data source
`define TX_NIB_W  4  // Quarter-rate nibble
`define TX_DEL_W  4  // Phase step code, 0 to 15 cycles
`define TX_NDIV_W 4  // Input divider ratio

`endif

/* run.sh */
#!/usr/bin/env bash
# Build and run the transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_tx_top \
    -Mdir obj_dir -o sim_tx
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tx)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

/* src/hr_16t4_mux.sv */
`timescale 1ns/1ps

`default_nettype none

`include "tx_defs.svh"

module hr_16t4_mux import tx_pack::*; (
    input wire logic mdll_clk,
    input wire logic reset,
    input wire logic en,                    // Transmitter enable
    input wire logic bit_tick,              // Bit-rate strobe
    input wire logic nib_req,               // Next nibble request from 4 to 1 mux
    input wire logic [`TX_WORD_W-1:0] din,  // Word, valid with prbs_strobe
    output logic prbs_strobe,               // Word request to data source
    output logic [`TX_NIB_W-1:0] nibble     // Current nibble, MSB nibble first
);

    tx_state_e             state_q;
    logic [1:0]            idx_q;  // Nibble index, 3 down to 0
    logic [`TX_WORD_W-1:0] word_q; // Captured word

    // First tick after enable, or request after the last nibble
    assign prbs_strobe = (state_q == TX_OFF && bit_tick) || (nib_req && idx_q == 2'd0);

    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            state_q <= TX_OFF;
            idx_q   <= 2'd0;
        end else if (!en) begin
            state_q <= TX_OFF; // Restart from a fresh word
            idx_q   <= 2'd0;
        end else if (prbs_strobe) begin
            state_q <= TX_RUN;
            idx_q   <= 2'd3; // din[15:12] goes out first
        end else if (nib_req) begin
            idx_q <= idx_q - 1'b1;
        end
    end

    // Word register, loaded in the strobe cycle
    always_ff @(posedge mdll_clk) begin
        if (prbs_strobe)
            word_q <= din;
    end

    assign nibble = word_q[{idx_q, 2'b00} +: `TX_NIB_W];

    // The bit mux only runs after a word has been captured
    a_req_in_run: assert property (@(posedge mdll_clk) disable iff (reset)
        nib_req |-> state_q == TX_RUN);

endmodule

`default_nettype wire

/* src/input_divider.sv */
`timescale 1ns/1ps

`default_nettype none

`include "tx_defs.svh"

module input_divider import tx_pack::*; (
    input wire logic mdll_clk, // Fast source clock
    input wire logic reset,
    tx_debug_intf.div cfg,
    output logic bit_tick      // One cycle in every N
);

    localparam logic [`TX_NDIV_W-1:0] RELOAD_ONE = {{(`TX_NDIV_W-1){1'b0}}, 1'b1};

    logic [`TX_NDIV_W-1:0] reload; // N-1 for the current mode
    logic [`TX_NDIV_W-1:0] cnt_q;  // Cycles left until next tick
    logic                  tick_q;

    // Bit period minus one
    always_comb begin
        case (cfg.div_mode)
            DIV_BY2: reload = RELOAD_ONE;
            DIV_BYN: begin
                // ndiv of 0 or 1 runs as divide by 2
                if (cfg.ndiv[`TX_NDIV_W-1:1] == '0)
                    reload = RELOAD_ONE;
                else
                    reload = cfg.ndiv - 1'b1;
            end
            default: reload = '0; // Bypass, tick every cycle
        endcase
    end

    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            cnt_q  <= '0;
            tick_q <= 1'b0;
        end else if (!cfg.en) begin
            cnt_q  <= '0; // Idle, next enable ticks right away
            tick_q <= 1'b0;
        end else if (cnt_q == '0) begin
            cnt_q  <= reload;
            tick_q <= 1'b1;
        end else begin
            cnt_q  <= cnt_q - 1'b1;
            tick_q <= 1'b0;
        end
    end

    assign bit_tick = tick_q & cfg.en; // No tick leaks out once en drops

    // Only bypass may tick back to back
    a_tick_spacing: assert property (@(posedge mdll_clk) disable iff (reset)
        (bit_tick && cfg.div_mode != DIV_BYPASS) |=> !bit_tick);

endmodule

`default_nettype wire

/* src/phase_interpolator.sv */
`timescale 1ns/1ps

`default_nettype none

`include "tx_defs.svh"

module phase_interpolator (
    input wire logic mdll_clk,
    input wire logic reset,
    tx_debug_intf.pi cfg,
    input wire logic ser_bit,  // Serial data from 4 to 1 mux
    output logic dout_p,       // Differential data out
    output logic dout_n
);

    localparam int unsigned N_TAP = 2 ** `TX_DEL_W; // One tap per code

    logic [`TX_DEL_W-1:0] del_q;          // Active delay code
    logic [N_TAP-2:0]     hist_q;         // Past ser_bit values
    logic [N_TAP-1:0]     taps;           // Tap 0 is the live bit
    logic                 tap;

    // Code only moves on ctl_valid
    always_ff @(posedge mdll_clk) begin
        if (reset)
            del_q <= '0;
        else if (cfg.ctl_valid)
            del_q <= cfg.del_code; // Used from the next cycle
    end

    assign taps = {hist_q, ser_bit};
    assign tap  = taps[del_q];

    always_ff @(posedge mdll_clk) begin
        hist_q <= taps[N_TAP-2:0]; // Shift by one cycle
    end

    // Output register adds the fixed one cycle
    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            dout_p <= 1'b0;
            dout_n <= 1'b0;
        end else begin
            dout_p <= cfg.en & tap;
            dout_n <= cfg.en & ~tap; // Both low when disabled
        end
    end

    a_diff_pair: assert property (@(posedge mdll_clk) disable iff (reset)
        $past(cfg.en) |-> dout_n == !dout_p);

endmodule

`default_nettype wire

/* src/qr_4t1_mux.sv */
`timescale 1ns/1ps

`default_nettype none

`include "tx_defs.svh"

module qr_4t1_mux import tx_pack::*; (
    input wire logic mdll_clk,
    input wire logic reset,
    input wire logic en,
    input wire logic bit_tick,
    input wire logic [`TX_NIB_W-1:0] nibble, // From 16 to 4 mux
    output logic ser_bit,                    // Serial data, MSB first
    output logic nib_req                     // Pulse on the last bit of a nibble
);

    tx_state_e             state_q;
    logic [1:0]            bit_cnt_q; // Bit position inside the nibble
    logic [`TX_NIB_W-2:0]  sh_q;      // Remaining bits after the MSB

    // Last bit of the nibble is on the line
    assign nib_req = bit_tick && state_q == TX_RUN && bit_cnt_q == 2'd3;

    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            state_q   <= TX_OFF;
            bit_cnt_q <= 2'd0;
        end else if (!en) begin
            state_q   <= TX_OFF;
            bit_cnt_q <= 2'd0;
        end else if (bit_tick) begin
            if (state_q == TX_OFF)
                state_q <= TX_RUN; // Strobe tick, the word loads upstream
            else
                bit_cnt_q <= bit_cnt_q + 1'b1; // Wraps to 0 after the request
        end
    end

    // Shift register of the current nibble
    always_ff @(posedge mdll_clk) begin
        if (bit_tick && state_q == TX_RUN) begin
            if (bit_cnt_q == 2'd0)
                sh_q <= nibble[`TX_NIB_W-2:0]; // MSB already sent straight from nibble
            else
                sh_q <= {sh_q[`TX_NIB_W-3:0], 1'b0};
        end
    end

    // First bit comes from the fresh nibble, the rest from the shifter
    always_comb begin
        if (state_q != TX_RUN)
            ser_bit = 1'b0;
        else if (bit_cnt_q == 2'd0)
            ser_bit = nibble[`TX_NIB_W-1];
        else
            ser_bit = sh_q[`TX_NIB_W-2];
    end

endmodule

`default_nettype wire

/* src/tx_debug_intf.sv */
`timescale 1ns/1ps

`default_nettype none

`include "tx_defs.svh"

// Static configuration and delay control for the transmitter
interface tx_debug_intf import tx_pack::*; ();

    logic                  en;        // Transmitter enable level
    div_mode_e             div_mode;  // Divider mode
    logic [`TX_NDIV_W-1:0] ndiv;      // Ratio for DIV_BYN
    logic [`TX_DEL_W-1:0]  del_code;  // Requested delay code
    logic                  ctl_valid; // One-cycle load pulse for del_code

    // Driven from top-level ports
    modport ctl (
        output en,
        output div_mode,
        output ndiv,
        output del_code,
        output ctl_valid
    );

    modport div (input en, input div_mode, input ndiv); // Input divider view

    modport pi (input en, input del_code, input ctl_valid); // Interpolator view

endinterface

`default_nettype wire

/* src/tx_pack.sv */
`default_nettype none

// Types shared by the transmitter blocks
package tx_pack;

    // Input divider ratio select
    typedef enum logic [1:0] {
        DIV_BYPASS = 2'd0, // Bit rate equals mdll_clk
        DIV_BY2    = 2'd1, // Half of mdll_clk
        DIV_BYN    = 2'd2  // Programmable ratio from ndiv
    } div_mode_e;

    // Word and nibble mux run state
    typedef enum logic {
        TX_OFF = 1'b0, // Waiting for first bit tick after enable
        TX_RUN = 1'b1  // Streaming words
    } tx_state_e;

endpackage

`default_nettype wire

/* src/tx_top.sv */
`timescale 1ns/1ps

`default_nettype none

`include "tx_defs.svh"

module tx_top import tx_pack::*; (
    input wire logic mdll_clk,                      // Fast source clock
    input wire logic reset,                         // Synchronous, active high
    input wire logic en,                            // Transmitter enable
    input wire div_mode_e div_mode,
    input wire logic [`TX_NDIV_W-1:0] ndiv,
    input wire logic [`TX_DEL_W-1:0] del_code,
    input wire logic ctl_valid,                     // Loads del_code
    input wire logic [`TX_WORD_W-1:0] din,          // Sampled when prbs_strobe is high
    output logic prbs_strobe,                       // Word request to PRBS source
    output logic dout_p,
    output logic dout_n
);

    tx_debug_intf tx_if ();

    logic                 bit_tick;
    logic                 nib_req;
    logic [`TX_NIB_W-1:0] nibble;
    logic                 ser_bit;

    // Plain ports onto the config bus
    assign tx_if.en        = en;
    assign tx_if.div_mode  = div_mode;
    assign tx_if.ndiv      = ndiv;
    assign tx_if.del_code  = del_code;
    assign tx_if.ctl_valid = ctl_valid;

    input_divider indiv (
        .mdll_clk (mdll_clk),
        .reset    (reset),
        .cfg      (tx_if.div),
        .bit_tick (bit_tick)
    );

    hr_16t4_mux hr_mux_16t4 (
        .mdll_clk    (mdll_clk),
        .reset       (reset),
        .en          (en),
        .bit_tick    (bit_tick),
        .nib_req     (nib_req),
        .din         (din),
        .prbs_strobe (prbs_strobe),
        .nibble      (nibble)
    );

    qr_4t1_mux qr_mux_4t1 (
        .mdll_clk (mdll_clk),
        .reset    (reset),
        .en       (en),
        .bit_tick (bit_tick),
        .nibble   (nibble),
        .ser_bit  (ser_bit),
        .nib_req  (nib_req)
    );

    // Single digital delay stands in for the four phases
    phase_interpolator i_pi (
        .mdll_clk (mdll_clk),
        .reset    (reset),
        .cfg      (tx_if.pi),
        .ser_bit  (ser_bit),
        .dout_p   (dout_p),
        .dout_n   (dout_n)
    );

endmodule

`default_nettype wire

/* test/tb_tx_top.sv */
`timescale 1ns/1ps

`default_nettype none

`include "tx_defs.svh"

module tb_tx_top import tx_pack::*; ();

    logic                  mdll_clk;
    logic                  reset;
    logic                  en;
    div_mode_e             div_mode;
    logic [`TX_NDIV_W-1:0] ndiv;
    logic [`TX_DEL_W-1:0]  del_code;
    logic                  ctl_valid;
    logic [`TX_WORD_W-1:0] din;
    logic                  prbs_strobe;
    logic                  dout_p;
    logic                  dout_n;

    integer    seed;
    logic      strobe_seen;  // Word request seen in the last cycle
    bit        timed_out;
    bit        ok;
    string     row_name[$];  // Stimulus table
    div_mode_e row_mode[$];
    int        row_ndiv[$];
    int        row_del[$];
    bit        row_ctl[$];   // Pulse ctl_valid with del_code
    int        row_words[$];

    tx_top i_tx_top (
        .mdll_clk    (mdll_clk),
        .reset       (reset),
        .en          (en),
        .div_mode    (div_mode),
        .ndiv        (ndiv),
        .del_code    (del_code),
        .ctl_valid   (ctl_valid),
        .din         (din),
        .prbs_strobe (prbs_strobe),
        .dout_p      (dout_p),
        .dout_n      (dout_n)
    );

    tx_checker i_chk (.*);

    initial mdll_clk = 1'b0;
    always #4 mdll_clk = ~mdll_clk; // 8 ns period

    always @(negedge mdll_clk) strobe_seen = prbs_strobe;

    // Fresh word once the previous one has been taken
    always @(posedge mdll_clk) begin
        if (strobe_seen) begin
            #1 din = 16'($random(seed));
        end
    end

    task automatic add_row(string name, div_mode_e m, int nd, int dl, bit ctl, int words);
        row_name.push_back(name);
        row_mode.push_back(m);
        row_ndiv.push_back(nd);
        row_del.push_back(dl);
        row_ctl.push_back(ctl);
        row_words.push_back(words);
    endtask

    task automatic next_cycle();
        @(posedge mdll_clk);
        #1;
    endtask

    // Count word requests, giving up after a bounded number of cycles
    task automatic wait_strobes(int count, output bit done);
        int seen;
        int waited;
        seen   = 0;
        waited = 0;
        done   = 1'b1;
        while (seen < count) begin
            @(negedge mdll_clk);
            if (prbs_strobe)
                seen++;
            waited++;
            if (waited > 300 * (count + 1)) begin
                done = 1'b0;
                break;
            end
        end
    endtask

    initial begin
        seed        = 32'hbd1e281f;
        reset       = 1'b1;
        en          = 1'b0;
        div_mode    = DIV_BYPASS;
        ndiv        = '0;
        del_code    = '0;
        ctl_valid   = 1'b0;
        strobe_seen = 1'b0;
        timed_out   = 1'b0;
        din         = 16'($random(seed));

        add_row("bypass",   DIV_BYPASS, 0, 0, 1'b0, 3); // Runs on the reset delay code
        add_row("div2",     DIV_BY2,    0, 0, 1'b0, 2);
        add_row("divn5",    DIV_BYN,    5, 0, 1'b0, 2);
        add_row("divn1",    DIV_BYN,    1, 0, 1'b0, 2);
        add_row("delay7",   DIV_BYPASS, 0, 7, 1'b1, 3);
        add_row("no_valid", DIV_BY2,    0, 3, 1'b0, 2); // Code 7 stays active
        add_row("restart",  DIV_BYN,    3, 0, 1'b1, 2);

        repeat (10) @(posedge mdll_clk);
        #1 reset = 1'b0;

        for (int i = 0; i < row_name.size(); i++) begin
            i_chk.start_test(row_name[i]);
            div_mode = row_mode[i];
            ndiv     = 4'(row_ndiv[i]);
            del_code = 4'(row_del[i]);
            if (row_ctl[i]) begin
                ctl_valid = 1'b1;
                next_cycle();
                ctl_valid = 1'b0;
            end
            next_cycle();
            en = 1'b1;
            // One extra request marks the end of the last full word
            wait_strobes(row_words[i] + 1, ok);
            if (!ok) begin
                $display("Timeout: the DUT stopped requesting words in test %s", row_name[i]);
                timed_out = 1'b1;
                break;
            end
            repeat (20) @(posedge mdll_clk); // Tail of the last word plus delay
            #1 en = 1'b0;
            repeat (4) next_cycle();
            i_chk.finish_test();
        end

        $display("tests %0d, bits checked %0d, errors %0d",
                 row_name.size(), i_chk.total_checks, i_chk.err_count);
        if (timed_out || i_chk.err_count != 0) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/tx_checker.sv */
`timescale 1ns/1ps

`default_nettype none

`include "tx_defs.svh"

module tx_checker import tx_pack::*; (
    input wire logic mdll_clk,
    input wire logic reset,
    input wire logic en,
    input wire div_mode_e div_mode,
    input wire logic [`TX_NDIV_W-1:0] ndiv,
    input wire logic [`TX_DEL_W-1:0] del_code,
    input wire logic ctl_valid,
    input wire logic [`TX_WORD_W-1:0] din,
    input wire logic prbs_strobe,
    input wire logic dout_p,
    input wire logic dout_n
);

    int    cyc;           // Rising edges seen so far
    int    d_act;         // Delay code the DUT should be using
    int    last_strobe;   // Cycle of the previous word request, -1 if none
    int    exp_cyc[$];    // Sample cycles of predicted bits, in order
    logic  exp_bit[$];
    logic  en_prev;
    string test_name;
    int    test_checks;
    int    test_errs;
    int    total_checks;
    int    err_count;

    // Bit period in mdll_clk cycles
    function automatic int bit_period(div_mode_e m, logic [`TX_NDIV_W-1:0] n);
        if (m == DIV_BYPASS)
            return 1;
        if (m == DIV_BY2)
            return 2;
        return (n < 2) ? 2 : int'(n); // Ratios 0 and 1 run as 2
    endfunction

    task automatic report_value(string what, int exp_v, int act_v);
        err_count++;
        test_errs++;
        $display("error %s expected %0d actual %0d (%s at cycle %0d)",
                 test_name, exp_v, act_v, what, cyc);
    endtask

    task automatic report_issue(string msg);
        err_count++;
        test_errs++;
        $display("%s: %s at cycle %0d", test_name, msg, cyc);
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic finish_test();
        if (test_checks == 0)
            report_issue("no serial bits were checked");
        $display("%s: %0d bits checked, %0d errors", test_name, test_checks, test_errs);
    endtask

    initial begin
        cyc          = 0;
        d_act        = 0;
        last_strobe  = -1;
        en_prev      = 1'b0;
        test_name    = "reset";
        test_checks  = 0;
        test_errs    = 0;
        total_checks = 0;
        err_count    = 0;
    end

    always @(posedge mdll_clk) cyc <= cyc + 1;

    // Outputs are settled at the falling edge
    always @(negedge mdll_clk) begin : watch
        int n;
        if (reset) begin
            if (cyc > 0 && (prbs_strobe || dout_p || dout_n))
                report_issue("outputs are not low during reset");
            d_act = 0;
            last_strobe = -1;
        end else begin
            if (!en && prbs_strobe)
                report_issue("word request while disabled");
            if (!en_prev) begin
                exp_cyc.delete(); // Words in flight are cut off
                exp_bit.delete();
                if (dout_p || dout_n)
                    report_issue("outputs are not low one cycle after disable");
            end else if (dout_n !== ~dout_p) begin
                report_issue("dout_n is not the complement of dout_p");
            end
            while (exp_cyc.size() > 0 && exp_cyc[0] == cyc) begin
                test_checks++;
                total_checks++;
                if (dout_p !== exp_bit[0])
                    report_value("dout_p", int'(exp_bit[0]), int'(dout_p));
                void'(exp_cyc.pop_front());
                void'(exp_bit.pop_front());
            end
            if (prbs_strobe) begin
                n = bit_period(div_mode, ndiv);
                if (last_strobe >= 0 && cyc - last_strobe != 16 * n)
                    report_value("strobe spacing", 16 * n, cyc - last_strobe);
                last_strobe = cyc;
                // MSB first, each bit sampled mid period
                for (int k = `TX_WORD_W - 1; k >= 0; k--) begin
                    exp_cyc.push_back(cyc + 2 + d_act + (15 - k) * n + n / 2);
                    exp_bit.push_back(din[k]);
                end
            end
            if (!en)
                last_strobe = -1;
            if (ctl_valid)
                d_act = int'(del_code); // Takes effect next cycle
        end
        en_prev = en;
    end

endmodule

`default_nettype wire
